//--- array_ctrl_pkg.sv
// array control shared definitions
package array_ctrl_pkg;

    localparam int cfg_addr_w   = 6;
    localparam int cfg_data_w   = 16;
    localparam int user_id_w    = 2;
    localparam int num_users    = 4;
    localparam int num_cfg_regs = 37;   // words 37..63 unimplemented
    localparam int num_ops      = 8;
    localparam int op_cfg_base  = 5;
    localparam int op_cfg_words = 4;    // acc_num, scale, bias, shift
    localparam int mac_mult_num = 4;
    localparam int wake_delay   = 5;    // weight memory wake-up

    typedef logic [cfg_addr_w-1:0] cfg_addr_t;
    typedef logic [cfg_data_w-1:0] cfg_data_t;
    typedef logic [user_id_w-1:0]  user_id_t;

    // model configuration words
    localparam cfg_addr_t addr_max_context_length       = 6'd0;
    localparam cfg_addr_t addr_qkv_weight_cols_per_core = 6'd1;
    localparam cfg_addr_t addr_token_per_core           = 6'd2;
    localparam cfg_addr_t addr_embd_size                = 6'd3;
    localparam cfg_addr_t addr_gqa_en                   = 6'd4;

    typedef struct packed {
        cfg_data_t acc_num;
        cfg_data_t quant_scale;
        cfg_data_t quant_bias;
        cfg_data_t quant_shift;
    } op_cfg_t;

    // index k follows the sequencer order q, k, v, qk, pv, proj, ffn0, ffn1
    typedef op_cfg_t [num_ops-1:0] op_cfg_bank_t;

    typedef struct packed {
        cfg_data_t max_context_length;
        cfg_data_t qkv_weight_cols_per_core;
        cfg_data_t token_per_core;
        cfg_data_t embd_size;
        cfg_data_t gqa_en;
    } model_cfg_t;

    typedef struct packed {
        cfg_data_t token_cnt;
        user_id_t  user_id;
        logic      kv_cache_not_full;
    } user_cfg_t;

    // state minus one gives the op index
    typedef enum logic [3:0] {
        idle   = 4'd0,
        q_gen  = 4'd1,
        k_gen  = 4'd2,
        v_gen  = 4'd3,
        att_qk = 4'd4,
        att_pv = 4'd5,
        proj   = 4'd6,
        ffn0   = 4'd7,
        ffn1   = 4'd8
    } ctrl_state_e;

endpackage

//--- ctrl_reg_file.sv
// configuration register file
`timescale 1ns/1ns

module ctrl_reg_file (
    input  logic                         clk,
    input  logic                         rst_n,
    input  array_ctrl_pkg::cfg_addr_t    reg_addr,
    input  array_ctrl_pkg::cfg_data_t    reg_wdata,
    input  logic                         reg_wen,
    input  logic                         reg_ren,
    input  logic                         cfg_init_success,
    output array_ctrl_pkg::cfg_data_t    reg_rdata,
    output logic                         reg_rvld,
    output array_ctrl_pkg::op_cfg_bank_t op_cfg_bank,
    output array_ctrl_pkg::cfg_data_t    max_context_length,
    output array_ctrl_pkg::model_cfg_t   model_cfg,
    output logic                         model_cfg_vld
);

    array_ctrl_pkg::cfg_addr_t  addr_d;
    array_ctrl_pkg::cfg_data_t  wdata_d;
    logic                       wen_d;
    logic                       ren_d;
    logic                       addr_ok;
    array_ctrl_pkg::cfg_data_t  regs [array_ctrl_pkg::num_cfg_regs];
    array_ctrl_pkg::model_cfg_t model_live;

    // host port retiming stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen_d <= 1'b0;
            ren_d <= 1'b0;
        end else begin
            wen_d <= reg_wen;
            ren_d <= reg_ren;
        end
    end

    always_ff @(posedge clk) begin
        addr_d  <= reg_addr;
        wdata_d <= reg_wdata;
    end

    assign addr_ok = addr_d < array_ctrl_pkg::cfg_addr_t'(array_ctrl_pkg::num_cfg_regs);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < array_ctrl_pkg::num_cfg_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_d && addr_ok) begin
            regs[addr_d] <= wdata_d;
        end
    end

    // read data lands with rvld, two cycles after ren
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rvld <= 1'b0;
        end else begin
            reg_rvld <= ren_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ren_d) begin
            reg_rdata <= addr_ok ? regs[addr_d] : '0;  // unmapped reads as zero
        end
    end

    always_comb begin
        model_live.max_context_length       = regs[array_ctrl_pkg::addr_max_context_length];
        model_live.qkv_weight_cols_per_core = regs[array_ctrl_pkg::addr_qkv_weight_cols_per_core];
        model_live.token_per_core           = regs[array_ctrl_pkg::addr_token_per_core];
        model_live.embd_size                = regs[array_ctrl_pkg::addr_embd_size];
        model_live.gqa_en                   = regs[array_ctrl_pkg::addr_gqa_en];
    end

    assign max_context_length = model_live.max_context_length;

    // four words per op
    always_comb begin
        for (int k = 0; k < array_ctrl_pkg::num_ops; k++) begin
            op_cfg_bank[k].acc_num     = regs[array_ctrl_pkg::op_cfg_base
                                              + array_ctrl_pkg::op_cfg_words * k];
            op_cfg_bank[k].quant_scale = regs[array_ctrl_pkg::op_cfg_base
                                              + array_ctrl_pkg::op_cfg_words * k + 1];
            op_cfg_bank[k].quant_bias  = regs[array_ctrl_pkg::op_cfg_base
                                              + array_ctrl_pkg::op_cfg_words * k + 2];
            op_cfg_bank[k].quant_shift = regs[array_ctrl_pkg::op_cfg_base
                                              + array_ctrl_pkg::op_cfg_words * k + 3];
        end
    end

    // model snapshot on init success
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_cfg_vld <= 1'b0;
        end else begin
            model_cfg_vld <= cfg_init_success;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_init_success) begin
            model_cfg <= model_live;
        end
    end

endmodule

//--- user_token_table.sv
// per-user token bookkeeping
`timescale 1ns/1ns

module user_token_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      new_token,
    input  logic                      user_first_token,
    input  array_ctrl_pkg::user_id_t  user_id,
    input  array_ctrl_pkg::cfg_data_t max_context_length,
    output array_ctrl_pkg::user_cfg_t usr_cfg,
    output logic                      usr_cfg_vld,
    output logic                      token_ready
);

    array_ctrl_pkg::cfg_data_t token_cnt   [array_ctrl_pkg::num_users];
    logic                      kv_not_full [array_ctrl_pkg::num_users];
    array_ctrl_pkg::cfg_data_t last_cnt;
    array_ctrl_pkg::user_id_t  cur_user;
    logic [2:0]                tok_dly;   // new_token delayed 1, 2, 3 cycles

    assign last_cnt = max_context_length - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < array_ctrl_pkg::num_users; i++) begin
                token_cnt[i]   <= '0;
                kv_not_full[i] <= 1'b1;
            end
        end else if (new_token) begin
            if (user_first_token) begin
                token_cnt[user_id]   <= '0;
                kv_not_full[user_id] <= 1'b1;
            end else if (token_cnt[user_id] == last_cnt) begin
                // context limit reached, cache now full
                token_cnt[user_id]   <= '0;
                kv_not_full[user_id] <= 1'b0;
            end else begin
                token_cnt[user_id] <= token_cnt[user_id] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_user <= '0;
            tok_dly  <= '0;
        end else begin
            if (new_token) begin
                cur_user <= user_id;
            end
            tok_dly <= {tok_dly[1:0], new_token};
        end
    end

    // entry already updated when tok_dly[0] is high
    always_ff @(posedge clk) begin
        if (tok_dly[0]) begin
            usr_cfg.token_cnt         <= token_cnt[cur_user];
            usr_cfg.user_id           <= cur_user;
            usr_cfg.kv_cache_not_full <= kv_not_full[cur_user];
        end
    end

    assign usr_cfg_vld = tok_dly[1];
    assign token_ready = tok_dly[2];   // one cycle after the record

endmodule

//--- op_sequencer.sv
// per-token operation sequencer
`timescale 1ns/1ns

module op_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         token_ready,
    input  logic                         op_finish,
    input  array_ctrl_pkg::op_cfg_bank_t op_cfg_bank,
    input  array_ctrl_pkg::user_cfg_t    usr_cfg,
    input  array_ctrl_pkg::cfg_data_t    max_context_length,
    input  logic                         power_mode_en,
    input  logic                         debug_en,
    input  logic [7:0]                   debug_bits,
    output array_ctrl_pkg::ctrl_state_e  control_state,
    output logic                         control_state_update,
    output array_ctrl_pkg::op_cfg_t      op_cfg,
    output logic                         op_cfg_vld,
    output logic                         op_start,
    output logic                         current_token_finish
);

    array_ctrl_pkg::ctrl_state_e state_q;
    array_ctrl_pkg::ctrl_state_e nxt_state;
    array_ctrl_pkg::op_cfg_t     sel_cfg;
    logic                        entered;    // first cycle after a state change
    logic                        power_mode_q;
    logic                        debug_en_q;
    logic [7:0]                  debug_bits_q;
    logic [2:0]                  op_idx;
    logic                        skip;
    logic                        wake_op;
    logic                        advance;
    logic                        nxt_update;
    logic                        nxt_cfg_vld;
    logic                        nxt_start;
    logic                        nxt_finish;
    logic [array_ctrl_pkg::wake_delay-1:0] wake_dly;

    function automatic array_ctrl_pkg::ctrl_state_e following_state(
        input array_ctrl_pkg::ctrl_state_e cur,
        input logic                        loop_back
    );
        array_ctrl_pkg::ctrl_state_e nxt;
        case (cur)
            array_ctrl_pkg::q_gen:  nxt = array_ctrl_pkg::k_gen;
            array_ctrl_pkg::k_gen:  nxt = array_ctrl_pkg::v_gen;
            array_ctrl_pkg::v_gen:  nxt = array_ctrl_pkg::att_qk;
            array_ctrl_pkg::att_qk: nxt = array_ctrl_pkg::att_pv;
            array_ctrl_pkg::att_pv: nxt = array_ctrl_pkg::proj;
            array_ctrl_pkg::proj:   nxt = array_ctrl_pkg::ffn0;
            array_ctrl_pkg::ffn0:   nxt = array_ctrl_pkg::ffn1;
            array_ctrl_pkg::ffn1:   nxt = loop_back ? array_ctrl_pkg::q_gen : array_ctrl_pkg::idle;
            default:                nxt = array_ctrl_pkg::idle;
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_mode_q <= 1'b0;
            debug_en_q   <= 1'b0;
            debug_bits_q <= '0;
            state_q      <= array_ctrl_pkg::idle;
            entered      <= 1'b0;
            wake_dly     <= '0;
        end else begin
            power_mode_q <= power_mode_en;
            debug_en_q   <= debug_en;
            debug_bits_q <= debug_bits;
            state_q      <= control_state;
            entered      <= control_state != state_q;
            // only q_gen and ffn0 feed the wake line
            wake_dly     <= {wake_dly[array_ctrl_pkg::wake_delay-2:0], op_cfg_vld && wake_op};
        end
    end

    assign op_idx  = 3'(control_state - 1'b1);
    assign skip    = debug_en_q && !debug_bits_q[op_idx];
    assign wake_op = (control_state == array_ctrl_pkg::q_gen)
                  || (control_state == array_ctrl_pkg::ffn0);

    always_comb begin
        sel_cfg = op_cfg_bank[op_idx];
        if (control_state == array_ctrl_pkg::att_pv) begin
            // pv accumulates over the cached tokens only
            if (usr_cfg.kv_cache_not_full) begin
                sel_cfg.acc_num = array_ctrl_pkg::cfg_data_t'(
                    usr_cfg.token_cnt / array_ctrl_pkg::mac_mult_num + 1);
            end else begin
                sel_cfg.acc_num = array_ctrl_pkg::cfg_data_t'(
                    max_context_length / array_ctrl_pkg::mac_mult_num);
            end
        end
    end

    always_comb begin
        nxt_state   = control_state;
        nxt_update  = 1'b0;
        nxt_cfg_vld = 1'b0;
        nxt_start   = 1'b0;
        nxt_finish  = 1'b0;
        advance     = 1'b0;
        if (control_state == array_ctrl_pkg::idle) begin
            if (token_ready) begin
                nxt_state  = array_ctrl_pkg::q_gen;
                nxt_update = 1'b1;
            end
        end else begin
            nxt_cfg_vld = entered && !skip;
            nxt_start   = wake_op ? wake_dly[array_ctrl_pkg::wake_delay-1] : op_cfg_vld;
            advance     = (entered && skip) || op_finish;
            if (advance) begin
                nxt_state  = following_state(control_state, power_mode_q);
                nxt_update = 1'b1;
                nxt_finish = control_state == array_ctrl_pkg::ffn1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            control_state        <= array_ctrl_pkg::idle;
            control_state_update <= 1'b0;
            op_cfg_vld           <= 1'b0;
            op_start             <= 1'b0;
            current_token_finish <= 1'b0;
        end else begin
            control_state        <= nxt_state;
            control_state_update <= nxt_update;
            op_cfg_vld           <= nxt_cfg_vld;
            op_start             <= nxt_start;
            current_token_finish <= nxt_finish;
        end
    end

    always_ff @(posedge clk) begin
        if (nxt_cfg_vld) begin
            op_cfg <= sel_cfg;
        end
    end

endmodule

//--- array_ctrl.sv
// array control top level
`timescale 1ns/1ns

module array_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    // host register port
    input  array_ctrl_pkg::cfg_addr_t   reg_addr,
    input  array_ctrl_pkg::cfg_data_t   reg_wdata,
    input  logic                        reg_wen,
    input  logic                        reg_ren,
    output array_ctrl_pkg::cfg_data_t   reg_rdata,
    output logic                        reg_rvld,
    // model channel
    input  logic                        cfg_init_success,
    output array_ctrl_pkg::model_cfg_t  model_cfg,
    output logic                        model_cfg_vld,
    // user channel
    input  logic                        new_token,
    input  logic                        user_first_token,
    input  array_ctrl_pkg::user_id_t    user_id,
    output array_ctrl_pkg::user_cfg_t   usr_cfg,
    output logic                        usr_cfg_vld,
    // op channel
    output array_ctrl_pkg::ctrl_state_e control_state,
    output logic                        control_state_update,
    output array_ctrl_pkg::op_cfg_t     op_cfg,
    output logic                        op_cfg_vld,
    output logic                        op_start,
    input  logic                        op_finish,
    output logic                        current_token_finish,
    // mode controls
    input  logic                        power_mode_en,
    input  logic                        debug_en,
    input  logic [7:0]                  debug_bits
);

    array_ctrl_pkg::op_cfg_bank_t op_cfg_bank;
    array_ctrl_pkg::cfg_data_t    max_context_length;
    logic                         token_ready;

    ctrl_reg_file u_reg_file (
        .clk                (clk),
        .rst_n              (rst_n),
        .reg_addr           (reg_addr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .reg_ren            (reg_ren),
        .cfg_init_success   (cfg_init_success),
        .reg_rdata          (reg_rdata),
        .reg_rvld           (reg_rvld),
        .op_cfg_bank        (op_cfg_bank),
        .max_context_length (max_context_length),
        .model_cfg          (model_cfg),
        .model_cfg_vld      (model_cfg_vld)
    );

    user_token_table u_token_table (
        .clk                (clk),
        .rst_n              (rst_n),
        .new_token          (new_token),
        .user_first_token   (user_first_token),
        .user_id            (user_id),
        .max_context_length (max_context_length),
        .usr_cfg            (usr_cfg),
        .usr_cfg_vld        (usr_cfg_vld),
        .token_ready        (token_ready)
    );

    op_sequencer u_sequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .token_ready          (token_ready),
        .op_finish            (op_finish),
        .op_cfg_bank          (op_cfg_bank),
        .usr_cfg              (usr_cfg),
        .max_context_length   (max_context_length),
        .power_mode_en        (power_mode_en),
        .debug_en             (debug_en),
        .debug_bits           (debug_bits),
        .control_state        (control_state),
        .control_state_update (control_state_update),
        .op_cfg               (op_cfg),
        .op_cfg_vld           (op_cfg_vld),
        .op_start             (op_start),
        .current_token_finish (current_token_finish)
    );

endmodule

//--- array_ctrl_props.sv
// array control timing assertions
`timescale 1ns/1ns

module array_ctrl_props (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        reg_ren,
    input logic                        reg_rvld,
    input array_ctrl_pkg::ctrl_state_e control_state,
    input logic                        op_cfg_vld,
    input logic                        op_start,
    input logic                        current_token_finish
);

    // read valid two cycles after the strobe, in both directions
    a_rvld_after_ren: assert property (@(posedge clk) disable iff (!rst_n)
        reg_ren |-> ##2 reg_rvld)
        else $error("reg_rvld missing two cycles after reg_ren");

    a_rvld_has_ren: assert property (@(posedge clk) disable iff (!rst_n)
        reg_rvld |-> $past(reg_ren, 2))
        else $error("reg_rvld without reg_ren two cycles before");

    a_quiet_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (control_state == array_ctrl_pkg::idle) |-> (!op_cfg_vld && !op_start))
        else $error("op_cfg_vld or op_start high in idle");

    a_finish_leaves_ffn1: assert property (@(posedge clk) disable iff (!rst_n)
        current_token_finish |->
            ($past(control_state) == array_ctrl_pkg::ffn1)
            && (control_state != array_ctrl_pkg::ffn1))
        else $error("current_token_finish not on exit from ffn1");

endmodule

//--- array_ctrl_tb.sv
// array control testbench
`timescale 1ns/1ns

module array_ctrl_tb;

    localparam int num_tokens = 20;     // upper bound on tokens issued
    localparam int max_ctx    = 8;

    logic                        clk = 1'b0;
    logic                        rst_n;
    array_ctrl_pkg::cfg_addr_t   reg_addr;
    array_ctrl_pkg::cfg_data_t   reg_wdata;
    logic                        reg_wen;
    logic                        reg_ren;
    array_ctrl_pkg::cfg_data_t   reg_rdata;
    logic                        reg_rvld;
    logic                        cfg_init_success;
    array_ctrl_pkg::model_cfg_t  model_cfg;
    logic                        model_cfg_vld;
    logic                        new_token;
    logic                        user_first_token;
    array_ctrl_pkg::user_id_t    user_id;
    array_ctrl_pkg::user_cfg_t   usr_cfg;
    logic                        usr_cfg_vld;
    array_ctrl_pkg::ctrl_state_e control_state;
    logic                        control_state_update;
    array_ctrl_pkg::op_cfg_t     op_cfg;
    logic                        op_cfg_vld;
    logic                        op_start;
    logic                        op_finish;
    logic                        current_token_finish;
    logic                        power_mode_en;
    logic                        debug_en;
    logic [7:0]                  debug_bits;

    array_ctrl_pkg::cfg_data_t   exp_regs [64];
    array_ctrl_pkg::cfg_data_t   exp_cnt  [4];
    logic                        exp_kvnf [4];
    array_ctrl_pkg::user_id_t    cur_uid;

    array_ctrl dut_i (.*);

    bind array_ctrl array_ctrl_props props_i (
        .clk(clk), .rst_n(rst_n), .reg_ren(reg_ren), .reg_rvld(reg_rvld),
        .control_state(control_state), .op_cfg_vld(op_cfg_vld), .op_start(op_start),
        .current_token_finish(current_token_finish)
    );

    always #20 clk = ~clk;

    task automatic fail_value(input string name, input logic [511:0] exp, input logic [511:0] act);
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_data(input string name, input array_ctrl_pkg::cfg_data_t act,
                              input array_ctrl_pkg::cfg_data_t exp);
        if (act !== exp) fail_value(name, exp, act);
    endtask

    task automatic check_op_cfg(input array_ctrl_pkg::op_cfg_t act,
                                input array_ctrl_pkg::op_cfg_t exp);
        if (act !== exp) fail_value("op_cfg", exp, act);
    endtask

    task automatic check_user_cfg(input array_ctrl_pkg::user_cfg_t act,
                                  input array_ctrl_pkg::user_cfg_t exp);
        if (act !== exp) fail_value("usr_cfg", exp, act);
    endtask

    task automatic check_model_cfg(input array_ctrl_pkg::model_cfg_t act,
                                   input array_ctrl_pkg::model_cfg_t exp);
        if (act !== exp) fail_value("model_cfg", exp, act);
    endtask

    task automatic check_state(input array_ctrl_pkg::ctrl_state_e act,
                               input array_ctrl_pkg::ctrl_state_e exp);
        if (act !== exp) fail_value("control_state", exp, act);
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) fail_value(name, exp, act);
    endtask

    // one clock, then settle past the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input array_ctrl_pkg::cfg_addr_t a, input array_ctrl_pkg::cfg_data_t d);
        reg_addr  = a;
        reg_wdata = d;
        reg_wen   = 1'b1;
        step();
        reg_wen   = 1'b0;
        if (a < 37) exp_regs[a] = d;
    endtask

    task automatic read_expect(input array_ctrl_pkg::cfg_addr_t a);
        reg_addr = a;
        reg_ren  = 1'b1;
        step();
        reg_ren  = 1'b0;
        check_bit("reg_rvld", reg_rvld, 1'b0);
        step();
        check_bit("reg_rvld", reg_rvld, 1'b1);
        check_data("reg_rdata", reg_rdata, (a < 37) ? exp_regs[a] : '0);
    endtask

    task automatic pulse_init();
        array_ctrl_pkg::model_cfg_t m;
        m = {exp_regs[0], exp_regs[1], exp_regs[2], exp_regs[3], exp_regs[4]};
        cfg_init_success = 1'b1;
        step();
        cfg_init_success = 1'b0;
        check_bit("model_cfg_vld", model_cfg_vld, 1'b1);
        check_model_cfg(model_cfg, m);
        step();
        check_bit("model_cfg_vld", model_cfg_vld, 1'b0);
    endtask

    function automatic array_ctrl_pkg::op_cfg_t expected_op(input int k);
        array_ctrl_pkg::op_cfg_t e;
        int base;
        base = 5 + 4 * k;
        e = {exp_regs[base], exp_regs[base+1], exp_regs[base+2], exp_regs[base+3]};
        if (k == 4) begin  // pv count from the token count
            e.acc_num = exp_kvnf[cur_uid] ? exp_cnt[cur_uid] / 4 + 1 : exp_regs[0] / 4;
        end
        return e;
    endfunction

    task automatic send_token(input array_ctrl_pkg::user_id_t uid, input logic first);
        array_ctrl_pkg::user_cfg_t e;
        new_token        = 1'b1;
        user_first_token = first;
        user_id          = uid;
        if (first) begin
            exp_cnt[uid]  = '0;
            exp_kvnf[uid] = 1'b1;
        end else if (exp_cnt[uid] == exp_regs[0] - 1) begin
            exp_cnt[uid]  = '0;
            exp_kvnf[uid] = 1'b0;
        end else begin
            exp_cnt[uid] = exp_cnt[uid] + 1;
        end
        cur_uid = uid;
        step();
        new_token = 1'b0;
        check_bit("usr_cfg_vld", usr_cfg_vld, 1'b0);
        step();
        check_bit("usr_cfg_vld", usr_cfg_vld, 1'b1);
        e = {exp_cnt[uid], uid, exp_kvnf[uid]};
        check_user_cfg(usr_cfg, e);
    endtask

    // follow one pass over the ops enabled in mask
    task automatic run_ops(input logic [7:0] mask, input array_ctrl_pkg::ctrl_state_e after);
        int gap;
        for (int k = 0; k < 8; k++) begin
            if (mask[k]) begin
                while (op_cfg_vld !== 1'b1) step();
                check_state(control_state, array_ctrl_pkg::ctrl_state_e'(k + 1));
                check_op_cfg(op_cfg, expected_op(k));
                check_bit("control_state_update", control_state_update, 1'b0);
                gap = (k == 0 || k == 6) ? 6 : 1;
                for (int i = 1; i <= gap; i++) begin
                    step();
                    check_bit("op_start", op_start, i == gap);
                end
            end
        end
        while (current_token_finish !== 1'b1) step();
        check_state(control_state, after);
        check_bit("control_state_update", control_state_update, 1'b1);
    endtask

    // op_finish answers each op_start
    always begin
        int d;
        step();
        if (op_start) begin
            d = $urandom_range(8, 1);
            repeat (d - 1) step();
            op_finish = 1'b1;
            step();
            op_finish = 1'b0;
        end
    end

    task automatic test_register_access();
        for (int a = 0; a < 37; a++) write_reg(a, 16'($urandom));
        for (int a = 0; a < 37; a++) read_expect(a);
        write_reg(40, 16'hbeef);
        read_expect(40);
    endtask

    task automatic test_model_snapshot();
        pulse_init();
        write_reg(3, exp_regs[3] ^ 16'h5a5a);
        repeat (3) step();
        check_data("model_cfg.embd_size", model_cfg.embd_size, exp_regs[3] ^ 16'h5a5a);
        pulse_init();
    endtask

    task automatic test_full_token();
        write_reg(0, max_ctx);
        send_token(0, 1'b1);
        run_ops(8'hff, array_ctrl_pkg::idle);
    endtask

    task automatic test_token_counting();
        debug_en   = 1'b1;
        debug_bits = 8'h10;             // pv only
        for (int t = 0; t < 9; t++) begin
            send_token(1, t == 0);
            run_ops(8'h10, array_ctrl_pkg::idle);
        end
        check_bit("kv_cache_not_full", usr_cfg.kv_cache_not_full, 1'b0);
        send_token(2, 1'b0);
        run_ops(8'h10, array_ctrl_pkg::idle);
        send_token(1, 1'b1);
        run_ops(8'h10, array_ctrl_pkg::idle);
    endtask

    task automatic test_debug_power();
        debug_bits = 8'b1010_0101;
        send_token(3, 1'b0);
        run_ops(8'b1010_0101, array_ctrl_pkg::idle);
        debug_bits    = 8'b1100_0001;
        power_mode_en = 1'b1;
        send_token(3, 1'b0);
        run_ops(8'b1100_0001, array_ctrl_pkg::q_gen);
        power_mode_en = 1'b0;
        run_ops(8'b1100_0001, array_ctrl_pkg::idle);
        debug_en = 1'b0;
    endtask

    initial begin
        #(num_tokens * 5000 * 40);
        $display("watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(81590));
        rst_n = 1'b0;
        {reg_addr, reg_wdata, reg_wen, reg_ren, cfg_init_success} = '0;
        {new_token, user_first_token, user_id, op_finish} = '0;
        {power_mode_en, debug_en, debug_bits} = '0;
        for (int i = 0; i < 64; i++) exp_regs[i] = '0;
        for (int u = 0; u < 4; u++) begin
            exp_cnt[u]  = '0;
            exp_kvnf[u] = 1'b1;
        end
        cur_uid = '0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        step();
        check_state(control_state, array_ctrl_pkg::idle);
        test_register_access();
        test_model_snapshot();
        test_full_token();
        test_token_counting();
        test_debug_power();
        repeat (5) step();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- all.f
array_ctrl_pkg.sv
ctrl_reg_file.sv
user_token_table.sv
op_sequencer.sv
array_ctrl.sv
array_ctrl_props.sv
array_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# build and run the array control simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module array_ctrl_tb \
    -f all.f -o array_ctrl_sim \
    && ./obj_dir/array_ctrl_sim \
    || exit 1
